// File: filelist.f
hw/lsu_pkg.sv
hw/mem_map_pkg.sv
hw/pipe_stage.sv
hw/lsu_decode.sv
hw/lsu_execute.sv
hw/lsu_result.sv
hw/data_ram.sv
hw/lsu_top.sv
tb/tb_clock.sv
tb/lsu_tb.sv

// File: hw/data_ram.sv
// byte-enable word ram
`timescale 1ns/1ps
`default_nettype none

module data_ram #(
  parameter int ram_words = mem_map_pkg::DEFAULT_RAM_WORDS
) (
  input  wire                              clk,
  input  wire                              en,
  input  wire                              we,
  input  wire  [31:0]                      addr,
  input  wire  [mem_map_pkg::WORD_W-1:0]   wdata,
  input  wire  [7:0]                       be,
  output logic [mem_map_pkg::WORD_W-1:0]   rdata
);

  localparam int AW = $clog2(ram_words);

  logic [mem_map_pkg::WORD_W-1:0] mem [ram_words];
  logic [AW-1:0]                  idx;

  assign idx = addr[AW-1:0];

  always_ff @(posedge clk) begin
    if (en) begin
      if (we) begin
        for (int i = 0; i < 8; i++) begin
          if (be[i]) mem[idx][i*8 +: 8] <= wdata[i*8 +: 8];
        end
      end else begin
        rdata <= mem[idx]; // held until the next read
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/lsu_decode.sv
// request decode
`timescale 1ns/1ps
`default_nettype none

module lsu_decode #(
  parameter int ram_words = mem_map_pkg::DEFAULT_RAM_WORDS
) (
  input  wire                  req_valid,
  output logic                 req_ready,
  input  lsu_pkg::mem_op_e     req_op,
  input  wire  [63:0]          req_addr,
  input  wire  [63:0]          req_wdata,
  output logic                 out_valid,
  output lsu_pkg::dec_req_t    out_data,
  input  wire                  out_ready
);

  logic [63:0] rel_addr;
  logic [63:0] word_full;
  logic [63:0] last_word;
  logic [3:0]  nbytes;
  logic        below_base;

  assign out_valid = req_valid;
  assign req_ready = out_ready;

  always_comb begin
    out_data.is_store  = 1'b0;
    out_data.is_signed = 1'b0;
    case (req_op)
      lsu_pkg::LB:  begin out_data.size = lsu_pkg::SZ_B; out_data.is_signed = 1'b1; end
      lsu_pkg::LH:  begin out_data.size = lsu_pkg::SZ_H; out_data.is_signed = 1'b1; end
      lsu_pkg::LW:  begin out_data.size = lsu_pkg::SZ_W; out_data.is_signed = 1'b1; end
      lsu_pkg::LBU: out_data.size = lsu_pkg::SZ_B;
      lsu_pkg::LHU: out_data.size = lsu_pkg::SZ_H;
      lsu_pkg::LWU: out_data.size = lsu_pkg::SZ_W;
      lsu_pkg::SB:  begin out_data.size = lsu_pkg::SZ_B; out_data.is_store = 1'b1; end
      lsu_pkg::SH:  begin out_data.size = lsu_pkg::SZ_H; out_data.is_store = 1'b1; end
      lsu_pkg::SW:  begin out_data.size = lsu_pkg::SZ_W; out_data.is_store = 1'b1; end
      lsu_pkg::SD:  begin out_data.size = lsu_pkg::SZ_D; out_data.is_store = 1'b1; end
      default:      out_data.size = lsu_pkg::SZ_D; // LD and unused codes
    endcase

    below_base = req_addr < mem_map_pkg::RAM_BASE;
    rel_addr   = req_addr - mem_map_pkg::RAM_BASE;
    word_full  = {3'b000, rel_addr[63:3]};
    nbytes     = 4'd1 << out_data.size;

    out_data.offset   = rel_addr[2:0];
    out_data.word_idx = word_full[31:0];
    out_data.split    = ({1'b0, rel_addr[2:0]} + nbytes) > 4'd8;

    // second word of a split access must also be inside the window
    last_word      = word_full + 64'(out_data.split);
    out_data.fault = below_base || (last_word >= 64'(ram_words));

    out_data.wdata = req_wdata;
  end

endmodule

`default_nettype wire

// File: hw/lsu_execute.sv
// beat sequencer
`timescale 1ns/1ps
`default_nettype none

module lsu_execute (
  input  wire                  clk,
  input  wire                  rst,
  input  wire                  in_valid,
  output logic                 in_ready,
  input  lsu_pkg::dec_req_t    in_data,
  output logic                 ram_en,
  output logic                 ram_we,
  output logic [31:0]          ram_addr,
  output logic [63:0]          ram_wdata,
  output logic [7:0]           ram_be,
  input  wire  [63:0]          ram_rdata,
  output logic                 out_valid,
  output lsu_pkg::raw_resp_t   out_data,
  input  wire                  out_ready
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_BEAT1,
    S_BEAT2,
    S_RWAIT,
    S_HOLD
  } state_e;

  state_e            state;
  lsu_pkg::dec_req_t req_q;
  logic [63:0]       first_q;  // low word of a split load
  logic [63:0]       last_q;
  logic [63:0]       last_word;
  logic [127:0]      wimg;
  logic [15:0]       base_mask;
  logic [15:0]       mask;

  assign in_ready  = state == S_IDLE;
  assign out_valid = (state == S_RWAIT) || (state == S_HOLD);

  always_comb begin
    case (req_q.size)
      lsu_pkg::SZ_B: base_mask = 16'h0001;
      lsu_pkg::SZ_H: base_mask = 16'h0003;
      lsu_pkg::SZ_W: base_mask = 16'h000f;
      default:       base_mask = 16'h00ff;
    endcase
    mask = base_mask << req_q.offset;
    wimg = {64'd0, req_q.wdata} << {req_q.offset, 3'b000};
  end

  always_comb begin
    ram_en    = 1'b0;
    ram_we    = 1'b0;
    ram_addr  = req_q.word_idx;
    ram_wdata = wimg[63:0];
    ram_be    = 8'h00;
    if (state == S_BEAT1) begin
      ram_en = 1'b1;
      ram_we = req_q.is_store;
      ram_be = req_q.is_store ? mask[7:0] : 8'h00;
    end else if (state == S_BEAT2) begin
      ram_en    = 1'b1;
      ram_we    = req_q.is_store;
      ram_addr  = req_q.word_idx + 32'd1;
      ram_wdata = wimg[127:64];
      ram_be    = req_q.is_store ? mask[15:8] : 8'h00;
    end
  end

  // last word comes straight from the ram in read wait, from the register in hold
  assign last_word = (state == S_RWAIT) ? ram_rdata : last_q;

  always_comb begin
    out_data.offset    = req_q.offset;
    out_data.size      = req_q.size;
    out_data.is_signed = req_q.is_signed;
    out_data.is_load   = !req_q.is_store;
    out_data.fault     = req_q.fault;
    out_data.lo_word   = 64'd0;
    out_data.hi_word   = 64'd0;
    if (!req_q.is_store && !req_q.fault) begin
      out_data.lo_word = req_q.split ? first_q : last_word;
      out_data.hi_word = req_q.split ? last_word : 64'd0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= S_IDLE;
    end else begin
      case (state)
        S_IDLE: if (in_valid) state <= in_data.fault ? S_HOLD : S_BEAT1;
        S_BEAT1: begin
          if (req_q.split) state <= S_BEAT2;
          else state <= req_q.is_store ? S_HOLD : S_RWAIT;
        end
        S_BEAT2: state <= req_q.is_store ? S_HOLD : S_RWAIT;
        S_RWAIT: state <= out_ready ? S_IDLE : S_HOLD;
        S_HOLD:  if (out_ready) state <= S_IDLE;
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_IDLE && in_valid) req_q <= in_data;
    if (state == S_BEAT2) first_q <= ram_rdata; // read of beat one
    if (state == S_RWAIT) last_q <= ram_rdata;
  end

endmodule

`default_nettype wire

// File: hw/lsu_pkg.sv
// load/store unit types
`default_nettype none

package lsu_pkg;

  typedef enum logic [3:0] {
    LB, LH, LW, LD,
    LBU, LHU, LWU,
    SB, SH, SW, SD
  } mem_op_e;

  // access size, log2 of the byte count
  typedef enum logic [1:0] {
    SZ_B = 2'd0,
    SZ_H = 2'd1,
    SZ_W = 2'd2,
    SZ_D = 2'd3
  } size_e;

  typedef struct packed {
    logic        is_store;
    size_e       size;
    logic        is_signed;
    logic [31:0] word_idx;
    logic [2:0]  offset;
    logic        split;     // touches two words
    logic        fault;
    logic [63:0] wdata;
  } dec_req_t;

  typedef struct packed {
    logic [63:0] lo_word;
    logic [63:0] hi_word;
    logic [2:0]  offset;
    size_e       size;
    logic        is_signed;
    logic        is_load;
    logic        fault;
  } raw_resp_t;

endpackage

`default_nettype wire

// File: hw/lsu_result.sv
// load data align and extend
`timescale 1ns/1ps
`default_nettype none

module lsu_result (
  input  wire                  in_valid,
  output logic                 in_ready,
  input  lsu_pkg::raw_resp_t   in_data,
  output logic                 resp_valid,
  output logic [63:0]          resp_rdata,
  output logic                 resp_fault,
  input  wire                  resp_ready
);

  logic [127:0] joined;
  logic [63:0]  ext;
  logic [63:0]  sel;

  assign resp_valid = in_valid;
  assign in_ready   = resp_ready;
  assign resp_fault = in_data.fault;

  always_comb begin
    joined = {in_data.hi_word, in_data.lo_word} >> {in_data.offset, 3'b000};
    sel    = joined[63:0];
    case (in_data.size)
      lsu_pkg::SZ_B: ext = in_data.is_signed ? {{56{sel[7]}}, sel[7:0]} : {56'd0, sel[7:0]};
      lsu_pkg::SZ_H: ext = in_data.is_signed ? {{48{sel[15]}}, sel[15:0]} : {48'd0, sel[15:0]};
      lsu_pkg::SZ_W: ext = in_data.is_signed ? {{32{sel[31]}}, sel[31:0]} : {32'd0, sel[31:0]};
      default:       ext = sel;
    endcase
    // stores and faults return zero
    resp_rdata = (in_data.is_load && !in_data.fault) ? ext : 64'd0;
  end

endmodule

`default_nettype wire

// File: hw/lsu_top.sv
// load/store unit top
`timescale 1ns/1ps
`default_nettype none

module lsu_top #(
  parameter int ram_words = mem_map_pkg::DEFAULT_RAM_WORDS
) (
  input  wire               clk,
  input  wire               rst,
  input  wire               req_valid,
  output logic              req_ready,
  input  lsu_pkg::mem_op_e  req_op,
  input  wire  [63:0]       req_addr,
  input  wire  [63:0]       req_wdata,
  output logic              resp_valid,
  input  wire               resp_ready,
  output logic [63:0]       resp_rdata,
  output logic              resp_fault
);

  lsu_pkg::dec_req_t  dec_data, exe_data;
  lsu_pkg::raw_resp_t raw_data, res_data;
  logic               dec_valid, dec_ready, exe_valid, exe_ready;
  logic               raw_valid, raw_ready, res_valid, res_ready;
  logic               ram_en, ram_we;
  logic [31:0]        ram_addr;
  logic [63:0]        ram_wdata, ram_rdata;
  logic [7:0]         ram_be;

  lsu_decode #(.ram_words(ram_words)) u_decode (
    .req_valid(req_valid), .req_ready(req_ready), .req_op(req_op),
    .req_addr(req_addr), .req_wdata(req_wdata),
    .out_valid(dec_valid), .out_data(dec_data), .out_ready(dec_ready)
  );

  pipe_stage #(.payload_t(lsu_pkg::dec_req_t)) dec_q (
    .clk(clk), .rst(rst),
    .in_valid(dec_valid), .in_ready(dec_ready), .in_data(dec_data),
    .out_valid(exe_valid), .out_data(exe_data), .out_ready(exe_ready)
  );

  lsu_execute u_execute (
    .clk(clk), .rst(rst),
    .in_valid(exe_valid), .in_ready(exe_ready), .in_data(exe_data),
    .ram_en(ram_en), .ram_we(ram_we), .ram_addr(ram_addr),
    .ram_wdata(ram_wdata), .ram_be(ram_be), .ram_rdata(ram_rdata),
    .out_valid(raw_valid), .out_data(raw_data), .out_ready(raw_ready)
  );

  data_ram #(.ram_words(ram_words)) u_ram (
    .clk(clk), .en(ram_en), .we(ram_we), .addr(ram_addr),
    .wdata(ram_wdata), .be(ram_be), .rdata(ram_rdata)
  );

  pipe_stage #(.payload_t(lsu_pkg::raw_resp_t)) res_q (
    .clk(clk), .rst(rst),
    .in_valid(raw_valid), .in_ready(raw_ready), .in_data(raw_data),
    .out_valid(res_valid), .out_data(res_data), .out_ready(res_ready)
  );

  lsu_result u_result (
    .in_valid(res_valid), .in_ready(res_ready), .in_data(res_data),
    .resp_valid(resp_valid), .resp_rdata(resp_rdata),
    .resp_fault(resp_fault), .resp_ready(resp_ready)
  );

endmodule

`default_nettype wire

// File: hw/mem_map_pkg.sv
// data memory map
`default_nettype none

package mem_map_pkg;

  // byte address of ram word 0
  localparam logic [63:0] RAM_BASE = 64'h8000_0000;

  localparam int WORD_W = 64;

  // ram depth in words unless the top overrides it
  localparam int DEFAULT_RAM_WORDS = 256;

endpackage

`default_nettype wire

// File: hw/pipe_stage.sv
// valid/ready skid stage
`timescale 1ns/1ps
`default_nettype none

module pipe_stage #(
  parameter type payload_t = logic [7:0]
) (
  input  wire      clk,
  input  wire      rst,
  input  wire      in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  output payload_t out_data,
  input  wire      out_ready
);

  payload_t skid_data;
  logic     skid_valid;
  logic     skid_valid_d;
  logic     main_take;
  logic     accept;

  always_comb begin
    main_take    = out_ready || !out_valid; // output slot free next edge
    accept       = in_valid && in_ready;
    skid_valid_d = skid_valid;
    if (main_take) begin
      skid_valid_d = 1'b0;
    end else if (accept) begin
      skid_valid_d = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
      in_ready   <= 1'b0;
    end else begin
      if (main_take) begin
        out_valid <= skid_valid || accept;
      end
      skid_valid <= skid_valid_d;
      in_ready   <= !skid_valid_d;
    end
  end

  always_ff @(posedge clk) begin
    if (main_take) begin
      out_data <= skid_valid ? skid_data : in_data;
    end
    if (!main_take && accept) begin
      skid_data <= in_data;
    end
  end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build and run the lsu testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --top-module lsu_tb -Mdir obj_dir -f filelist.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vlsu_tb
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi
exit 0

// File: tb/lsu_tb.sv
// load/store unit testbench
`timescale 1ns/1ps
`default_nettype none

module lsu_tb;

  localparam int RAM_BYTES = mem_map_pkg::DEFAULT_RAM_WORDS * 8;
  localparam int N_INIT    = mem_map_pkg::DEFAULT_RAM_WORDS;
  localparam int N_SIZES   = 4 * 8 * 5;
  localparam int N_EXT     = 2 * 7;
  localparam int N_FAULT   = 6;
  localparam int N_RAND    = 200;
  localparam int N_REQ     = N_INIT + 2 + N_SIZES + N_EXT + N_FAULT + N_RAND;
  localparam int WATCHDOG_NS = N_REQ * 20 * 20 + 2000 * 20;

  wire              clk;
  wire              rst;
  logic             req_valid;
  wire              req_ready;
  lsu_pkg::mem_op_e req_op;
  logic [63:0]      req_addr;
  logic [63:0]      req_wdata;
  wire              resp_valid;
  logic             resp_ready;
  wire  [63:0]      resp_rdata;
  wire              resp_fault;

  logic [7:0]  model [RAM_BYTES];  // byte image of the ram window
  logic [64:0] exp_q [$];          // fault bit over data in issue order
  logic [64:0] head;
  int          n_resp;
  logic        rand_ready;

  tb_clock clock_gen (.clk(clk), .rst(rst));

  lsu_top uut (
    .clk(clk), .rst(rst), .req_valid(req_valid), .req_ready(req_ready),
    .req_op(req_op), .req_addr(req_addr), .req_wdata(req_wdata),
    .resp_valid(resp_valid), .resp_ready(resp_ready),
    .resp_rdata(resp_rdata), .resp_fault(resp_fault)
  );

  function automatic int op_bytes(lsu_pkg::mem_op_e op);
    case (op)
      lsu_pkg::LB, lsu_pkg::LBU, lsu_pkg::SB: return 1;
      lsu_pkg::LH, lsu_pkg::LHU, lsu_pkg::SH: return 2;
      lsu_pkg::LW, lsu_pkg::LWU, lsu_pkg::SW: return 4;
      default:                                return 8;
    endcase
  endfunction

  task automatic check(input logic [63:0] got, input logic [63:0] expected,
                       input string what);
    if (got !== expected) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, what, got, expected);
      $display("Regression failed");
      $fatal(1, "compare error");
    end
  endtask

  // applies one access to the byte image and returns {fault, data}
  task automatic model_access(input lsu_pkg::mem_op_e op, input logic [63:0] addr,
                              input logic [63:0] wdata, output logic [64:0] result);
    int          n;
    int          base;
    logic [63:0] rel;
    logic [63:0] data;
    logic        store;
    logic        fault;
    n     = op_bytes(op);
    store = op inside {lsu_pkg::SB, lsu_pkg::SH, lsu_pkg::SW, lsu_pkg::SD};
    rel   = addr - mem_map_pkg::RAM_BASE;
    fault = (addr < mem_map_pkg::RAM_BASE) || (rel + 64'(n) > 64'(RAM_BYTES));
    data  = 64'd0;
    if (!fault) begin
      base = int'(rel[15:0]);
      for (int i = 0; i < n; i++) begin
        if (store) model[base + i] = wdata[8*i +: 8];
        else data[8*i +: 8] = model[base + i];
      end
      if (op inside {lsu_pkg::LB, lsu_pkg::LH, lsu_pkg::LW} && data[8*n-1]) begin
        data = data | (~64'd0 << (8 * n)); // sign fill
      end
    end
    result = {fault, data};
  endtask

  // call on a falling edge; returns on the falling edge after the transfer
  task automatic send(input lsu_pkg::mem_op_e op, input logic [63:0] addr,
                      input logic [63:0] wdata);
    logic [64:0] expected;
    logic        accepted;
    model_access(op, addr, wdata, expected);
    exp_q.push_back(expected);
    req_valid = 1'b1;
    req_op    = op;
    req_addr  = addr;
    req_wdata = wdata;
    accepted  = 1'b0;
    while (!accepted) begin
      accepted = req_ready;
      @(negedge clk);
    end
    req_valid = 1'b0;
  endtask

  task automatic drain();
    while (n_resp != exp_q.size()) @(negedge clk);
  endtask

  task automatic fill_ram();
    logic [63:0] a;
    for (int w = 0; w < N_INIT; w++) begin
      a = mem_map_pkg::RAM_BASE + 64'(w * 8);
      send(lsu_pkg::SD, a, (a * 64'h9e37_79b9_7f4a_7c15) ^ {a[31:0], a[63:32]});
    end
    drain();
  endtask

  task automatic aligned_store_load();
    logic [63:0] a;
    a = mem_map_pkg::RAM_BASE + 64'h40;
    send(lsu_pkg::SD, a, 64'h0123_4567_89ab_cdef);
    send(lsu_pkg::LD, a, 64'd0);
    drain();
  endtask

  // every size at every offset with both surrounding words
  task automatic size_offset_sweep();
    lsu_pkg::mem_op_e st [4];
    lsu_pkg::mem_op_e ls [4];
    lsu_pkg::mem_op_e lu [4];
    logic [63:0]      a;
    logic [63:0]      w;
    st = '{lsu_pkg::SB, lsu_pkg::SH, lsu_pkg::SW, lsu_pkg::SD};
    ls = '{lsu_pkg::LB, lsu_pkg::LH, lsu_pkg::LW, lsu_pkg::LD};
    lu = '{lsu_pkg::LBU, lsu_pkg::LHU, lsu_pkg::LWU, lsu_pkg::LD};
    for (int s = 0; s < 4; s++) begin
      for (int off = 0; off < 8; off++) begin
        w = mem_map_pkg::RAM_BASE + 64'((8 + 2 * (s * 8 + off)) * 8);
        a = w + 64'(off);
        send(st[s], a, {$urandom, $urandom});
        send(ls[s], a, 64'd0);
        send(lu[s], a, 64'd0);
        send(lsu_pkg::LD, w, 64'd0);
        send(lsu_pkg::LD, w + 64'd8, 64'd0);
      end
    end
    drain();
  endtask

  task automatic sign_extension();
    logic [63:0] a;
    logic [63:0] pat [2];
    pat = '{64'hf7e6_d5c4_b3a2_9180, 64'h0817_2635_4453_6271}; // top bits set, then clear
    a = mem_map_pkg::RAM_BASE + 64'h400;
    for (int p = 0; p < 2; p++) begin
      send(lsu_pkg::SD, a, pat[p]);
      send(lsu_pkg::LB, a, 64'd0);
      send(lsu_pkg::LBU, a, 64'd0);
      send(lsu_pkg::LH, a, 64'd0);
      send(lsu_pkg::LHU, a, 64'd0);
      send(lsu_pkg::LW, a, 64'd0);
      send(lsu_pkg::LWU, a, 64'd0);
    end
    drain();
  endtask

  task automatic fault_addresses();
    logic [63:0] end_addr;
    end_addr = mem_map_pkg::RAM_BASE + 64'(RAM_BYTES);
    send(lsu_pkg::SD, mem_map_pkg::RAM_BASE - 64'd8, 64'hdead_beef_dead_beef);
    send(lsu_pkg::LD, mem_map_pkg::RAM_BASE - 64'd1, 64'd0);
    send(lsu_pkg::SW, end_addr - 64'd2, 64'h1234_5678); // split past the end
    send(lsu_pkg::LB, end_addr, 64'd0);
    send(lsu_pkg::LD, end_addr - 64'd8, 64'd0);
    send(lsu_pkg::LD, mem_map_pkg::RAM_BASE, 64'd0);
    drain();
  endtask

  task automatic random_traffic();
    lsu_pkg::mem_op_e op;
    logic [63:0]      a;
    rand_ready = 1'b1;
    for (int i = 0; i < N_RAND; i++) begin
      op = lsu_pkg::mem_op_e'(4'($urandom_range(0, 10)));
      a  = mem_map_pkg::RAM_BASE - 64'd16 + 64'($urandom_range(0, RAM_BYTES + 31));
      send(op, a, {$urandom, $urandom});
      repeat ($urandom_range(0, 2)) @(negedge clk);
    end
    drain();
    rand_ready = 1'b0;
  endtask

  // response side sampled on the falling edge
  initial begin
    resp_ready = 1'b0;
    n_resp     = 0;
    forever begin
      @(negedge clk);
      resp_ready = rand_ready ? 1'($urandom_range(0, 1)) : 1'b1;
      if (resp_valid && resp_ready) begin
        if (n_resp >= exp_q.size()) begin
          $display("a response arrived with no request outstanding at %0t", $time);
          $display("Regression failed");
          $fatal(1, "unexpected response");
        end else begin
          head = exp_q[n_resp];
          check({63'd0, resp_fault}, {63'd0, head[64]}, "fault");
          check(resp_rdata, head[63:0], "rdata");
          n_resp++;
        end
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the tests did not finish in the expected time");
    $display("Regression failed");
    $fatal(1, "watchdog expired");
  end

  initial begin
    void'($urandom(32'h1d61));
    req_valid  = 1'b0;
    req_op     = lsu_pkg::LB;
    req_addr   = 64'd0;
    req_wdata  = 64'd0;
    rand_ready = 1'b0;
    wait (rst === 1'b0);
    @(negedge clk);
    fill_ram();
    aligned_store_load();
    size_offset_sweep();
    sign_extension();
    fault_addresses();
    random_traffic();
    // longer than the worst latency so a stray response still shows up
    repeat (10) @(negedge clk);
    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb/tb_clock.sv
// testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk; // 20 ns period
  end

  initial begin
    rst = 1'b1;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

`default_nettype wire
